// ==== hdl/vga_timing_pkg.sv ====
package vga_timing_pkg;

	// Horizontal raster, in pixel clocks
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;   // 800

	// Vertical raster, in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;   // 525

	// Sync pulse windows, start inclusive and end exclusive
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int HS_END   = HS_START + H_SYNC;
	localparam int VS_START = V_ACTIVE + V_FRONT;
	localparam int VS_END   = VS_START + V_SYNC;

	// Register stages between fetch output and output stage input
	localparam int PIPE_DEPTH = 2;

	// Pixel column and row
	typedef logic [11:0] coord_t;

endpackage

// ==== hdl/pixel_pkg.sv ====
package pixel_pkg;

	// RGB565 field widths
	localparam int RED_W = 5;
	localparam int GRN_W = 6;
	localparam int BLU_W = 5;

	// Raw FIFO word, red in the top bits
	typedef logic [RED_W+GRN_W+BLU_W-1:0] pixel_word_t;

	// Field order follows the word layout, so a plain cast unpacks it
	typedef struct packed {
		logic [RED_W-1:0] red;
		logic [GRN_W-1:0] green;
		logic [BLU_W-1:0] blue;
	} rgb_t;

	// 2R + G + 2B tops out at 187
	typedef logic [7:0] luma_t;

	typedef logic [7:0] threshold_t;

	// Pixel as it moves down the pipe
	typedef struct packed {
		logic valid;
		rgb_t color;
	} pix_t;

	localparam rgb_t RGB_BLACK = '0;
	localparam rgb_t RGB_WHITE = '1;

	localparam pix_t PIX_NONE = '0;   // Bubble, invalid and black

endpackage

// ==== hdl/vga_timing.sv ====
`timescale 1ns/10ps

module vga_timing (
	input  logic clk_out,
	input  logic rst_n,
	output logic hsync,
	output logic vsync,
	output logic video_on,
	output logic frame_start
);
	import vga_timing_pkg::*;

	localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
	localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);

	coord_t h_cnt, v_cnt;     // Position of the current cycle
	coord_t h_next, v_next;   // Position of the next cycle

	// Counter advance, column wraps first and carries into the row
	always_comb begin
		h_next = h_cnt + 1'b1;
		v_next = v_cnt;
		if (h_cnt == H_LAST) begin
			h_next = '0;
			if (v_cnt == V_LAST)
				v_next = '0;
			else
				v_next = v_cnt + 1'b1;
		end
	end

	// Outputs are decoded from the next position so that they land
	// on the same edge as the counters they describe
	always_ff @(posedge clk_out or negedge rst_n) begin
		if (!rst_n) begin
			h_cnt       <= '0;
			v_cnt       <= '0;
			hsync       <= 1'b1;   // Inactive high
			vsync       <= 1'b1;
			video_on    <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;

			hsync <= !(h_next >= coord_t'(HS_START) && h_next < coord_t'(HS_END));
			vsync <= !(v_next >= coord_t'(VS_START) && v_next < coord_t'(VS_END));

			video_on <= (h_next < coord_t'(H_ACTIVE)) && (v_next < coord_t'(V_ACTIVE));

			// Only fires on the wrap, so the first pulse is one frame after reset
			frame_start <= (h_next == '0) && (v_next == '0);
		end
	end

endmodule

// ==== hdl/pixel_fetch.sv ====
`timescale 1ns/10ps

module pixel_fetch (
	input  logic                   clk_out,
	input  logic                   rst_n,
	input  logic                   frame_start,
	input  logic                   video_on,
	input  logic                   empty_fifo,
	input  pixel_pkg::pixel_word_t din,
	output logic                   rd_en,
	output pixel_pkg::pix_t        pix
);
	import pixel_pkg::*;

	typedef enum logic [1:0] {
		wait_frame,
		idle,
		display
	} fetch_state_t;

	fetch_state_t state_q, state_d;

	logic start_ok;      // Frame boundary with data waiting
	logic fetch_slot;    // Cycle that may consume a word
	rgb_t word_rgb;

	assign start_ok = frame_start && !empty_fifo;

	// Next state, reading only ever begins or resumes on a frame boundary
	always_comb begin
		state_d = state_q;
		case (state_q)
			wait_frame: begin
				if (frame_start)
					state_d = idle;
			end
			idle: begin
				if (start_ok)
					state_d = display;
			end
			display: begin
				if (frame_start && empty_fifo)
					state_d = idle;   // Retest at the next boundary
			end
			default: state_d = wait_frame;
		endcase
	end

	always_ff @(posedge clk_out or negedge rst_n) begin
		if (!rst_n)
			state_q <= wait_frame;
		else
			state_q <= state_d;
	end

	// The (0,0) pixel arrives with frame_start, so the cycle that enters
	// display already counts as a display cycle
	assign fetch_slot = (state_q == display) || (state_q == idle && frame_start);

	// FWFT FIFO, din is the front word whenever it is not empty
	assign rd_en = fetch_slot && video_on && !empty_fifo;

	assign word_rgb = rgb_t'(din);   // RGB565 unpack

	// One pix per clock, bubble when nothing was popped
	always_ff @(posedge clk_out or negedge rst_n) begin
		if (!rst_n) begin
			pix <= PIX_NONE;
		end else if (rd_en) begin
			pix.valid <= 1'b1;
			pix.color <= word_rgb;
		end else begin
			pix <= PIX_NONE;
		end
	end

endmodule

// ==== hdl/edge_filter.sv ====
`timescale 1ns/10ps

module edge_filter (
	input  logic                  clk_out,
	input  logic                  rst_n,
	input  logic                  edge_mode,
	input  pixel_pkg::threshold_t threshold,
	input  pixel_pkg::pix_t       pix_in,
	output pixel_pkg::pix_t       pix_out
);
	import pixel_pkg::*;

	luma_t luma;
	luma_t luma_prev;    // Luma of the last valid pixel, zero after a gap
	luma_t grad;         // Absolute horizontal gradient
	logic  is_edge;
	rgb_t  color_d;

	// Cheap luma, weights 2:1:2 to balance the 6-bit green field
	assign luma = luma_t'({pix_in.color.red, 1'b0})
	            + luma_t'(pix_in.color.green)
	            + luma_t'({pix_in.color.blue, 1'b0});

	always_comb begin
		if (luma >= luma_prev)
			grad = luma - luma_prev;
		else
			grad = luma_prev - luma;
	end

	assign is_edge = grad > threshold;

	always_comb begin
		if (!pix_in.valid)
			color_d = RGB_BLACK;
		else if (edge_mode)
			color_d = is_edge ? RGB_WHITE : RGB_BLACK;
		else
			color_d = pix_in.color;   // Passthrough
	end

	always_ff @(posedge clk_out or negedge rst_n) begin
		if (!rst_n) begin
			luma_prev <= '0;
			pix_out   <= PIX_NONE;
		end else begin
			// Blanking and FIFO gaps break the line, restart from zero
			luma_prev     <= pix_in.valid ? luma : luma_t'(0);
			pix_out.valid <= pix_in.valid;
			pix_out.color <= color_d;
		end
	end

endmodule

// ==== hdl/vga_output.sv ====
`timescale 1ns/10ps

module vga_output (
	input  logic                         clk_out,
	input  logic                         rst_n,
	input  pixel_pkg::pix_t              pix,
	input  logic                         hsync,
	input  logic                         vsync,
	output logic [pixel_pkg::RED_W-1:0]  vga_out_r,
	output logic [pixel_pkg::GRN_W-1:0]  vga_out_g,
	output logic [pixel_pkg::BLU_W-1:0]  vga_out_b,
	output logic                         vga_out_hs,
	output logic                         vga_out_vs
);
	import vga_timing_pkg::*;
	import pixel_pkg::*;

	// Sync delay lines, matching fetch and filter latency
	logic [PIPE_DEPTH-1:0] hs_pipe;
	logic [PIPE_DEPTH-1:0] vs_pipe;
	rgb_t color_d;

	assign color_d = pix.valid ? pix.color : RGB_BLACK;   // Blank bubbles

	always_ff @(posedge clk_out or negedge rst_n) begin
		if (!rst_n) begin
			hs_pipe    <= '1;   // Syncs idle high
			vs_pipe    <= '1;
			vga_out_hs <= 1'b1;
			vga_out_vs <= 1'b1;
			vga_out_r  <= '0;
			vga_out_g  <= '0;
			vga_out_b  <= '0;
		end else begin
			hs_pipe <= {hs_pipe[PIPE_DEPTH-2:0], hsync};
			vs_pipe <= {vs_pipe[PIPE_DEPTH-2:0], vsync};

			// Final stage, syncs and colour leave on the same edge
			vga_out_hs <= hs_pipe[PIPE_DEPTH-1];
			vga_out_vs <= vs_pipe[PIPE_DEPTH-1];
			vga_out_r  <= color_d.red;
			vga_out_g  <= color_d.green;
			vga_out_b  <= color_d.blue;
		end
	end

endmodule

// ==== hdl/vga_interface.sv ====
`timescale 1ns/10ps

module vga_interface (
	input  logic                         clk_out,     // 25 MHz pixel clock
	input  logic                         rst_n,
	input  logic                         edge_mode,
	input  pixel_pkg::threshold_t        threshold,
	// Async FIFO read side
	input  logic                         empty_fifo,
	input  pixel_pkg::pixel_word_t       din,
	output logic                         rd_en,
	// VGA connector
	output logic [pixel_pkg::RED_W-1:0]  vga_out_r,
	output logic [pixel_pkg::GRN_W-1:0]  vga_out_g,
	output logic [pixel_pkg::BLU_W-1:0]  vga_out_b,
	output logic                         vga_out_hs,
	output logic                         vga_out_vs
);
	import pixel_pkg::*;

	logic hsync, vsync;
	logic video_on;
	logic frame_start;
	pix_t pix_fetch;     // Decoded pixel
	pix_t pix_filt;      // After edge filter

	vga_timing u_vga_timing (
		.clk_out     (clk_out),
		.rst_n       (rst_n),
		.hsync       (hsync),
		.vsync       (vsync),
		.video_on    (video_on),
		.frame_start (frame_start)
	);

	pixel_fetch u_pixel_fetch (
		.clk_out     (clk_out),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.video_on    (video_on),
		.empty_fifo  (empty_fifo),
		.din         (din),
		.rd_en       (rd_en),
		.pix         (pix_fetch)
	);

	edge_filter u_edge_filter (
		.clk_out   (clk_out),
		.rst_n     (rst_n),
		.edge_mode (edge_mode),
		.threshold (threshold),
		.pix_in    (pix_fetch),
		.pix_out   (pix_filt)
	);

	// Syncs enter here undelayed, the output stage lines them up
	vga_output u_vga_output (
		.clk_out    (clk_out),
		.rst_n      (rst_n),
		.pix        (pix_filt),
		.hsync      (hsync),
		.vsync      (vsync),
		.vga_out_r  (vga_out_r),
		.vga_out_g  (vga_out_g),
		.vga_out_b  (vga_out_b),
		.vga_out_hs (vga_out_hs),
		.vga_out_vs (vga_out_vs)
	);

endmodule

// ==== sim/vga_interface_assertions.sv ====
`timescale 1ns/10ps

module vga_interface_assertions (
	input logic                         clk_out,
	input logic                         rst_n,
	input logic                         rd_en,
	input logic                         empty_fifo,
	input logic [pixel_pkg::RED_W-1:0]  vga_out_r,
	input logic [pixel_pkg::GRN_W-1:0]  vga_out_g,
	input logic [pixel_pkg::BLU_W-1:0]  vga_out_b,
	input logic                         vga_out_hs,
	input logic                         vga_out_vs
);
	import vga_timing_pkg::*;

	coord_t hs_low_cnt;   // Length of the current hsync low run

	always_ff @(posedge clk_out or negedge rst_n) begin
		if (!rst_n)
			hs_low_cnt <= '0;
		else if (!vga_out_hs)
			hs_low_cnt <= hs_low_cnt + 1'b1;
		else
			hs_low_cnt <= '0;
	end

	// Front word is only there while the FIFO is not empty
	no_pop_when_empty: assert property (@(posedge clk_out) disable iff (!rst_n)
		!(rd_en && empty_fifo))
		else $error("rd_en high while empty_fifo is high");

	hsync_width: assert property (@(posedge clk_out) disable iff (!rst_n)
		$rose(vga_out_hs) |-> hs_low_cnt == coord_t'(H_SYNC))
		else $error("hsync low pulse is not %0d cycles long", H_SYNC);

	blank_in_vsync: assert property (@(posedge clk_out) disable iff (!rst_n)
		!vga_out_vs |-> (vga_out_r == '0 && vga_out_g == '0 && vga_out_b == '0))
		else $error("colour output not black during vsync");

endmodule

bind vga_interface vga_interface_assertions u_vga_interface_assertions (
	.clk_out    (clk_out),
	.rst_n      (rst_n),
	.rd_en      (rd_en),
	.empty_fifo (empty_fifo),
	.vga_out_r  (vga_out_r),
	.vga_out_g  (vga_out_g),
	.vga_out_b  (vga_out_b),
	.vga_out_hs (vga_out_hs),
	.vga_out_vs (vga_out_vs)
);

// ==== sim/vga_interface_tb.sv ====
`timescale 1ns/10ps

module vga_interface_tb;
	import pixel_pkg::*;
	import vga_timing_pkg::*;

	localparam int N_ROWS  = 4 * H_ACTIVE;      // Four visible lines of words
	localparam int GAP_LEN = 4;                 // Empty cycles per scheduled gap
	localparam int FRAME   = H_TOTAL * V_TOTAL;

	typedef struct packed {
		pixel_word_t word;
		logic        edge_mode;
		threshold_t  thr;
		logic        gap;                       // Empty cycles before this word
	} row_t;

	logic             clk_out;
	logic             rst_n;
	logic             edge_mode;
	threshold_t       threshold;
	logic             empty_fifo;
	pixel_word_t      din;
	logic             rd_en;
	logic [RED_W-1:0] vga_out_r;
	logic [GRN_W-1:0] vga_out_g;
	logic [BLU_W-1:0] vga_out_b;
	logic             vga_out_hs;
	logic             vga_out_vs;

	row_t   tbl [N_ROWS];
	int     pop_cycles [$];                     // Cycle index of every pop
	int     idx;
	int     gap_left;
	int     k;                                  // Cycles since reset release
	integer seed;
	bit     timed_out;
	int     checks [6];
	int     errs [6];
	string  names [6];

	// Reference pipeline of fetch, filter and output register
	bit          p1_valid;
	pixel_word_t p1_word;
	int          p1_row;
	int          p1_cat;
	pixel_word_t q_filt;
	pixel_word_t q_out;
	int          q_filt_cat;
	int          q_out_cat;
	int          luma_prev;

	vga_interface u_vga_interface (
		.clk_out    (clk_out),
		.rst_n      (rst_n),
		.edge_mode  (edge_mode),
		.threshold  (threshold),
		.empty_fifo (empty_fifo),
		.din        (din),
		.rd_en      (rd_en),
		.vga_out_r  (vga_out_r),
		.vga_out_g  (vga_out_g),
		.vga_out_b  (vga_out_b),
		.vga_out_hs (vga_out_hs),
		.vga_out_vs (vga_out_vs)
	);

	initial begin
		clk_out = 1'b0;
		forever #20 clk_out = ~clk_out;
	end

	function automatic int luma_of(input pixel_word_t w);
		return 2 * int'(w[15:11]) + int'(w[10:5]) + 2 * int'(w[4:0]);
	endfunction

	// Negative sync is low inside the pulse window
	function automatic bit sync_level(input int pos, input int start, input int len);
		return !(pos >= start && pos < start + len);
	endfunction

	task automatic check_val(input int cat, input string name, input int got, input int exp);
		checks[cat]++;
		assert (got == exp) else begin
			errs[cat]++;
			$display("Fail %0t %s: got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic print_result(input int i);
		$display("%-12s %0d checks, %0d errors", names[i], checks[i], errs[i]);
	endtask

	task automatic build_table();
		int          i;
		int          line;
		int          col;
		pixel_word_t w;
		pixel_word_t fixed_words [8];
		int          thr_a [4];
		int          thr_b [4];
		fixed_words = '{16'hFFFF, 16'h0000, 16'hFFFF, 16'hF800,
		                16'h07E0, 16'h001F, 16'h0841, 16'h0000};
		thr_a = '{0, 20, 60, 120};
		thr_b = '{10, 30, 90, 200};
		for (i = 0; i < N_ROWS; i++) begin
			line = i / H_ACTIVE;
			col  = i % H_ACTIVE;
			if (col < 8)
				w = fixed_words[col];    // Hard edges and pure primaries
			else
				w = pixel_word_t'($random(seed));
			tbl[i].word = w;
			case (line)
				0: begin
					tbl[i].edge_mode = 1'b0;
					tbl[i].thr       = '0;
					tbl[i].gap       = 1'b0;
				end
				1: begin
					tbl[i].edge_mode = 1'b1;
					tbl[i].thr       = threshold_t'(thr_a[col / 160]);
					tbl[i].gap       = 1'b0;
				end
				2: begin
					tbl[i].edge_mode = 1'b1;
					tbl[i].thr       = threshold_t'(thr_b[col / 160]);
					tbl[i].gap       = (col % 97 == 50);
				end
				default: begin
					tbl[i].edge_mode = 1'b0;
					tbl[i].thr       = '0;
					tbl[i].gap       = (col % 61 == 30);
				end
			endcase
		end
	endtask

	// The FIFO model updates its front word after each clock
	task automatic step();
		@(posedge clk_out);
		#2;
		if (pop_cycles.size() > idx) begin
			idx = pop_cycles.size();
			if (idx < N_ROWS && tbl[idx].gap)
				gap_left = GAP_LEN;
		end else if (gap_left > 0) begin
			gap_left--;
		end
		// Filter settings follow the word that is now in the filter stage
		if (idx > 0) begin
			edge_mode = tbl[idx-1].edge_mode;
			threshold = tbl[idx-1].thr;
		end
		if (idx < N_ROWS) begin
			din        = tbl[idx].word;
			empty_fifo = (gap_left > 0);
		end else begin
			empty_fifo = 1'b1;           // Drained
		end
	endtask

	task automatic wait_first_read(input int limit);
		int n;
		n = 0;
		while (pop_cycles.size() == 0 && n < limit) begin
			step();
			n++;
		end
		if (pop_cycles.size() == 0) begin
			$display("Timeout: no read strobe within %0d cycles after reset", limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (idx < N_ROWS && n < limit) begin
			step();
			n++;
		end
		if (idx < N_ROWS) begin
			$display("Timeout: only %0d of %0d words were read", idx, N_ROWS);
			timed_out = 1'b1;
		end
	endtask

	// Sampled mid cycle away from the driving edge
	always @(negedge clk_out) begin
		int x, y, frm, j, rd_cat, l, diff;
		bit active, exp_rd, exp_hs, exp_vs;
		if (!rst_n) begin
			check_val(0, "rd_en", int'(rd_en), 0);
			check_val(0, "vga_out_r", int'(vga_out_r), 0);
			check_val(0, "vga_out_g", int'(vga_out_g), 0);
			check_val(0, "vga_out_b", int'(vga_out_b), 0);
			check_val(0, "vga_out_hs", int'(vga_out_hs), 1);
			check_val(0, "vga_out_vs", int'(vga_out_vs), 1);
		end else begin
			x      = k % H_TOTAL;
			y      = (k / H_TOTAL) % V_TOTAL;
			frm    = k / FRAME;
			active = (x < H_ACTIVE) && (y < V_ACTIVE);
			// The first frame start only arms the fetch and the second finds data
			exp_rd = (frm >= 2) && active && !empty_fifo;
			if (frm < 2 || !active)
				rd_cat = 5;
			else if (empty_fifo)
				rd_cat = 4;
			else
				rd_cat = 2;
			check_val(rd_cat, "rd_en", int'(rd_en), int'(exp_rd));

			j      = (k >= 3) ? k - 3 : 0;   // Syncs trail the raster by three stages
			exp_hs = sync_level(j % H_TOTAL, H_ACTIVE + H_FRONT, H_SYNC);
			exp_vs = sync_level((j / H_TOTAL) % V_TOTAL, V_ACTIVE + V_FRONT, V_SYNC);
			check_val(1, "vga_out_hs", int'(vga_out_hs), int'(exp_hs));
			check_val(1, "vga_out_vs", int'(vga_out_vs), int'(exp_vs));

			check_val(q_out_cat, "vga_out_r", int'(vga_out_r), int'(q_out[15:11]));
			check_val(q_out_cat, "vga_out_g", int'(vga_out_g), int'(q_out[10:5]));
			check_val(q_out_cat, "vga_out_b", int'(vga_out_b), int'(q_out[4:0]));
			q_out     = q_filt;
			q_out_cat = q_filt_cat;

			if (p1_valid) begin
				l    = luma_of(p1_word);
				diff = (l > luma_prev) ? l - luma_prev : luma_prev - l;
				if (tbl[p1_row].edge_mode) begin
					q_filt     = (diff > int'(tbl[p1_row].thr)) ? 16'hFFFF : 16'h0000;
					q_filt_cat = 3;
				end else begin
					q_filt     = p1_word;
					q_filt_cat = 2;
				end
				luma_prev = l;
			end else begin
				q_filt     = '0;
				q_filt_cat = p1_cat;
				luma_prev  = 0;            // Gap or blanking restarts the gradient
			end

			p1_valid = rd_en;
			p1_word  = din;
			p1_row   = idx;
			p1_cat   = (frm >= 2 && active) ? 4 : 5;
			if (rd_en)
				pop_cycles.push_back(k);
			k++;
		end
	end

	initial begin
		int i;
		int tc;
		int te;
		rst_n      = 1'b0;
		edge_mode  = 1'b0;
		threshold  = '0;
		empty_fifo = 1'b1;
		din        = '0;
		idx        = 0;
		gap_left   = 0;
		k          = 0;
		seed       = 89915;
		timed_out  = 1'b0;
		q_out_cat  = 5;
		q_filt_cat = 5;
		p1_cat     = 5;
		p1_row     = 0;
		names = '{"reset", "raster", "passthrough", "edge mode", "underflow", "blanking"};
		build_table();

		repeat (2) step();
		rst_n = 1'b1;
		repeat (3) step();
		print_result(0);

		wait_first_read(3 * FRAME);
		if (!timed_out) begin
			check_val(5, "first rd_en cycle", pop_cycles[0], 2 * FRAME);
			wait_drained(10 * H_TOTAL);
		end
		if (!timed_out) begin
			repeat (2 * H_TOTAL) step();  // Flush the tail of the last line
			check_val(2, "pop count", pop_cycles.size(), N_ROWS);
		end

		tc = 0;
		te = 0;
		for (i = 1; i < 6; i++)
			print_result(i);
		for (i = 0; i < 6; i++) begin
			tc += checks[i];
			te += errs[i];
		end
		$display("Checks %0d, errors %0d", tc, te);
		if (te == 0 && !timed_out)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
hdl/vga_timing_pkg.sv
hdl/pixel_pkg.sv
hdl/vga_timing.sv
hdl/pixel_fetch.sv
hdl/edge_filter.sv
hdl/vga_output.sv
hdl/vga_interface.sv
sim/vga_interface_assertions.sv
sim/vga_interface_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = vga_interface_tb
FILELIST   = list.f
OBJ_DIR    = obj_dir
PASS_MSG   = TEST OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
